// File: bench/cache_properties.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_properties (
	input logic clk,
	input logic arst_n,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic [`CACHE_ADDR_W-1:0] pmem_addr,
	input cache_pkg::ctrl_state_t state
);

	assert property (@(posedge clk) disable iff (!arst_n) !(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write are high together");

	// an unanswered memory request keeps its address
	assert property (@(posedge clk) disable iff (!arst_n)
		(pmem_read && !pmem_resp) |=> (pmem_read && $stable(pmem_addr)))
		else $error("pmem_read or pmem_addr changed before pmem_resp");

	assert property (@(posedge clk) disable iff (!arst_n)
		(pmem_write && !pmem_resp) |=> (pmem_write && $stable(pmem_addr)))
		else $error("pmem_write or pmem_addr changed before pmem_resp");

	// the request was already there for the lookup cycle before the response
	assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |-> ((mem_read || mem_write) && $past(mem_read || mem_write)))
		else $error("mem_resp without a processor request held since the lookup");

	assert property (@(posedge clk) disable iff (!arst_n) mem_resp |=> !mem_resp)
		else $error("mem_resp stayed high for more than one cycle");

	assert property (@(posedge clk) disable iff (!arst_n)
		pmem_write |-> (state == cache_pkg::write_back))
		else $error("pmem_write outside the write-back state");

	assert property (@(posedge clk) disable iff (!arst_n)
		pmem_read |-> (state == cache_pkg::allocate))
		else $error("pmem_read outside the allocate state");

endmodule

bind cache_top cache_properties u_properties (
	.clk(clk),
	.arst_n(arst_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.pmem_addr(pmem_addr),
	.state(u_ctrl.state)
);

// File: bench/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb;

	localparam int NUM_REQUESTS = 500;
	localparam int REQ_TIMEOUT = 100; // cycles for one request, write-back and fill included
	localparam int LINE_WORDS = 2**(`CACHE_OFFSET_W-2);

	logic clk;
	logic arst_n;
	logic [`CACHE_ADDR_W-1:0] mem_addr;
	logic mem_read;
	logic mem_write;
	logic [31:0] mem_wdata;
	logic [3:0] mem_byte_enable;
	logic [31:0] mem_rdata;
	logic mem_resp;
	logic pmem_resp;
	cache_pkg::line_t pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic [`CACHE_ADDR_W-1:0] pmem_addr;
	cache_pkg::line_t pmem_wdata;

	integer seed = 32'h5f81;
	int pmem_count = 0; // memory transactions served so far

	logic [31:0] ref_word [logic [31:0]]; // processor view, holds only the words written
	cache_pkg::line_t mem_line [logic [31:0]]; // lines the cache has written back
	bit line_dirty [logic [31:0]];

	cache_top UUT (
		.clk,
		.arst_n,
		.mem_addr,
		.mem_read,
		.mem_write,
		.mem_wdata,
		.mem_byte_enable,
		.mem_rdata,
		.mem_resp,
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_addr,
		.pmem_wdata
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// starting memory contents, every address bit takes part
	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9) ^ 32'h5a3c_c3a5;
	endfunction

	function automatic logic [31:0] line_of(input logic [31:0] addr);
		return {addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		if (ref_word.exists(addr))
			return ref_word[addr];
		return init_word(addr);
	endfunction

	function automatic cache_pkg::line_t model_line(input logic [31:0] line_addr);
		cache_pkg::line_t line;
		for (int w = 0; w < LINE_WORDS; w++)
			line[32*w +: 32] = model_word(line_addr + 32'(4*w));
		return line;
	endfunction

	function automatic cache_pkg::line_t memory_line(input logic [31:0] line_addr);
		cache_pkg::line_t line;
		if (mem_line.exists(line_addr))
			return mem_line[line_addr];
		for (int w = 0; w < LINE_WORDS; w++)
			line[32*w +: 32] = init_word(line_addr + 32'(4*w));
		return line;
	endfunction

	// three tags on sets 1 and 6, so two ways per set overflow and lines get evicted
	function automatic logic [31:0] pick_addr();
		cache_pkg::tag_t tag;
		cache_pkg::index_t index;
		logic [2:0] word;
		case ({$random(seed)} % 3)
			0: tag = 24'h00_0012;
			1: tag = 24'h0a_bc00;
			default: tag = 24'h7f_0031;
		endcase
		index = ({$random(seed)} % 2 == 0) ? 3'd1 : 3'd6;
		word = 3'({$random(seed)} % LINE_WORDS);
		return {tag, index, word, 2'b00};
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
			fail_now($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, expected));
	endtask

	// holds one request until mem_resp, returns the read word and the cycles it took
	task automatic run_request(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] be,
		output logic [31:0] rdata, output int cycles);
		mem_addr = addr;
		mem_read = !write;
		mem_write = write;
		mem_wdata = wdata;
		mem_byte_enable = be;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!mem_resp && cycles < REQ_TIMEOUT);
		assert (mem_resp)
		else
			fail_now($sformatf("request to %h got no mem_resp within %0d cycles",
				addr, REQ_TIMEOUT));
		rdata = mem_rdata;
		@(negedge clk); // the response is taken at the rising edge in between
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic do_write(input logic [31:0] addr);
		logic [31:0] wdata;
		logic [3:0] be;
		logic [31:0] word;
		logic [31:0] rdata;
		int cycles;
		wdata = $random(seed);
		be = 4'({$random(seed)} % 15 + 1); // at least one byte enabled
		run_request(1'b1, addr, wdata, be, rdata, cycles);
		word = model_word(addr);
		for (int b = 0; b < 4; b++)
			if (be[b])
				word[8*b +: 8] = wdata[8*b +: 8];
		ref_word[addr] = word;
		line_dirty[line_of(addr)] = 1'b1;
	endtask

	task automatic do_read(input logic [31:0] addr, input bit expect_hit);
		logic [31:0] rdata;
		int cycles;
		int served;
		served = pmem_count;
		run_request(1'b0, addr, 32'd0, 4'd0, rdata, cycles);
		check_value("mem_rdata", rdata, model_word(addr));
		if (expect_hit)
		begin
			assert (cycles == 1 && pmem_count == served)
			else
				fail_now($sformatf("read of the touched line at %h went to memory or took %0d cycles",
					addr, cycles));
		end
	endtask

	// memory side, answers each line request after a random delay
	initial
	begin : memory_model
		int delay;
		logic [31:0] addr;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever
		begin
			@(negedge clk);
			pmem_resp = 1'b0;
			if (arst_n && (pmem_read || pmem_write))
			begin
				assert (!(pmem_read && pmem_write))
				else
					fail_now("memory read and memory write were requested together");
				addr = pmem_addr;
				assert (addr == line_of(addr))
				else
					fail_now($sformatf("error at %0t: pmem_addr is %h, expected %h",
						$time, addr, line_of(addr)));
				delay = {$random(seed)} % 6;
				repeat (delay) @(negedge clk);
				if (pmem_write)
				begin
					assert (pmem_wdata === model_line(addr))
					else
						fail_now($sformatf("error at %0t: pmem_wdata is %h, expected %h",
							$time, pmem_wdata, model_line(addr)));
					assert (line_dirty.exists(addr) && line_dirty[addr])
					else
						fail_now($sformatf("line %h was written back without a write since its fill",
							addr));
					mem_line[addr] = pmem_wdata;
				end
				else
					pmem_rdata = memory_line(addr);
				line_dirty[addr] = 1'b0; // a fill brings a clean line, a write-back ends it
				pmem_count++;
				pmem_resp = 1'b1;
			end
		end
	end

	initial
	begin : stimulus
		logic [31:0] addr;
		arst_n = 1'b0;
		mem_addr = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_value("mem_resp", 32'(mem_resp), 32'd0);
		check_value("pmem_read", 32'(pmem_read), 32'd0);
		check_value("pmem_write", 32'(pmem_write), 32'd0);
		for (int n = 0; n < NUM_REQUESTS; n++)
		begin
			addr = pick_addr();
			if ({$random(seed)} % 2 == 0)
				do_write(addr);
			else
				do_read(addr, 1'b0);
			if ({$random(seed)} % 4 == 0)
				do_read(addr, 1'b1); // same line again, it must still be cached
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// File: design/bus_adapter.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module bus_adapter (
	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	input logic [31:0] mem_wdata,
	input logic [3:0] mem_byte_enable,
	input cache_pkg::line_t line_rdata,
	output logic [31:0] mem_rdata,
	way_if.feed ways [`CACHE_WAYS]
);

	localparam int NUM_WORDS = 2**(`CACHE_OFFSET_W-2);

	logic [`CACHE_OFFSET_W-3:0] word_sel;
	cache_pkg::tag_t tag;
	cache_pkg::index_t index;
	cache_pkg::line_t wdata_line;
	cache_pkg::line_be_t be_line;

	assign word_sel = mem_addr[`CACHE_OFFSET_W-1:2];
	assign tag = mem_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W+`CACHE_INDEX_W];
	assign index = mem_addr[`CACHE_OFFSET_W+`CACHE_INDEX_W-1:`CACHE_OFFSET_W];

	// the word sits in every slot, only the enables pick the slot that is written
	assign wdata_line = {NUM_WORDS{mem_wdata}};
	assign be_line = cache_pkg::line_be_t'(mem_byte_enable) << (word_sel * 4);

	assign mem_rdata = line_rdata[word_sel*32 +: 32];

	for (genvar g = 0; g < `CACHE_WAYS; g++)
	begin : g_feed
		assign ways[g].index = index;
		assign ways[g].tag = tag;
		assign ways[g].wdata_line = wdata_line;
		assign ways[g].be_line = be_line;
	end

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl (
	input logic clk,
	input logic arst_n,

	input logic mem_read,
	input logic mem_write,
	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	output logic mem_resp,

	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input logic victim_dirty,
	input cache_pkg::tag_t victim_tag,
	input cache_pkg::line_t victim_line,

	output logic lookup,
	output logic [`CACHE_WAYS-1:0] fill,
	output logic [`CACHE_WAYS-1:0] write_hit,
	output logic update_lru,
	output logic evicting,

	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic [`CACHE_ADDR_W-1:0] pmem_addr,
	output cache_pkg::line_t pmem_wdata
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t next_state;
	logic request;
	logic looked; // the stores hold the entries of the current request
	logic miss;
	cache_pkg::index_t index;

	assign request = mem_read | mem_write;
	assign index = mem_addr[`CACHE_OFFSET_W+`CACHE_INDEX_W-1:`CACHE_OFFSET_W];

	assign lookup = (state == cache_pkg::check_tag) && request;
	assign miss = lookup && looked && !hit;
	assign mem_resp = lookup && looked && hit;
	assign update_lru = mem_resp;
	assign evicting = (state == cache_pkg::write_back);

	always_comb
	begin
		fill = '0;
		write_hit = '0;
		if (state == cache_pkg::allocate && pmem_read && pmem_resp)
			fill[victim_way] = 1'b1;
		if (mem_resp && mem_write)
			write_hit[hit_way] = 1'b1;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			cache_pkg::check_tag:
			begin
				if (miss)
					next_state = victim_dirty ? cache_pkg::write_back : cache_pkg::allocate;
			end
			cache_pkg::write_back:
			begin
				if (pmem_write && pmem_resp)
					next_state = cache_pkg::allocate;
			end
			cache_pkg::allocate:
			begin
				if (pmem_read && pmem_resp)
					next_state = cache_pkg::check_tag;
			end
			default:
				next_state = cache_pkg::check_tag;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= cache_pkg::check_tag;
			looked <= 1'b0;
			pmem_read <= 1'b0;
			pmem_write <= 1'b0;
		end
		else
		begin
			state <= next_state;
			looked <= lookup && !mem_resp && !miss; // a retry after a fill looks up again
			pmem_write <= (state == cache_pkg::write_back) && !(pmem_write && pmem_resp);
			pmem_read <= (state == cache_pkg::allocate) && !(pmem_read && pmem_resp);
		end
	end

	// address and line load in the cycle the request goes out
	always_ff @(posedge clk)
	begin
		if (state == cache_pkg::write_back && !pmem_write)
		begin
			pmem_addr <= {victim_tag, index, {`CACHE_OFFSET_W{1'b0}}};
			pmem_wdata <= victim_line;
		end
		else if (state == cache_pkg::allocate && !pmem_read)
			pmem_addr <= {mem_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
	end

endmodule

// File: design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address width on both the processor and the memory side
`define CACHE_ADDR_W 32

// 32-byte lines, so the low five address bits pick a byte in the line
`define CACHE_OFFSET_W 5

// eight sets
`define CACHE_INDEX_W 3

// two ways only, the replacement state is a single bit per set
`define CACHE_WAYS 2

`endif

// File: design/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-`CACHE_INDEX_W-1:0] tag_t;

	typedef logic [`CACHE_INDEX_W-1:0] index_t;

	typedef logic [8*(2**`CACHE_OFFSET_W)-1:0] line_t;

	// one enable per byte of a line
	typedef logic [(2**`CACHE_OFFSET_W)-1:0] line_be_t;

	typedef struct packed
	{
		logic valid;
		logic dirty;
		tag_t tag;
	} way_entry_t;

	typedef enum logic [1:0]
	{
		check_tag,
		write_back,
		allocate
	} ctrl_state_t;

endpackage

// File: design/cache_top.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_top (
	input logic clk,
	input logic arst_n,

	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	input logic mem_read,
	input logic mem_write,
	input logic [31:0] mem_wdata,
	input logic [3:0] mem_byte_enable,
	output logic [31:0] mem_rdata,
	output logic mem_resp,

	input logic pmem_resp,
	input cache_pkg::line_t pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output logic [`CACHE_ADDR_W-1:0] pmem_addr,
	output cache_pkg::line_t pmem_wdata
);

	way_if ways [`CACHE_WAYS] ();

	logic lookup;
	logic [`CACHE_WAYS-1:0] fill;
	logic [`CACHE_WAYS-1:0] write_hit;
	logic update_lru;
	logic evicting;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	cache_pkg::tag_t victim_tag;
	cache_pkg::line_t line_out;

	bus_adapter u_adapter (
		.mem_addr,
		.mem_wdata,
		.mem_byte_enable,
		.line_rdata(line_out),
		.mem_rdata,
		.ways
	);

	for (genvar g = 0; g < `CACHE_WAYS; g++)
	begin : g_way
		// controller strobes reach each way here
		assign ways[g].lookup = lookup;
		assign ways[g].fill = fill[g];
		assign ways[g].write_hit = write_hit[g];
		assign ways[g].fill_line = pmem_rdata;

		cache_way u_way (
			.clk,
			.arst_n,
			.bus(ways[g])
		);
	end

	way_select u_select (
		.clk,
		.arst_n,
		.ways,
		.update_lru,
		.evicting,
		.hit,
		.hit_way,
		.victim_way,
		.victim_dirty,
		.victim_tag,
		.line_out
	);

	cache_ctrl u_ctrl (
		.clk,
		.arst_n,
		.mem_read,
		.mem_write,
		.mem_addr,
		.mem_resp,
		.hit,
		.hit_way,
		.victim_way,
		.victim_dirty,
		.victim_tag,
		.victim_line(line_out), // the selector switches to the victim while evicting
		.lookup,
		.fill,
		.write_hit,
		.update_lru,
		.evicting,
		.pmem_resp,
		.pmem_read,
		.pmem_write,
		.pmem_addr,
		.pmem_wdata
	);

endmodule

// File: design/cache_way.sv
`timescale 1ns/1ps

module cache_way (
	input logic clk,
	input logic arst_n,
	way_if.way bus
);

	localparam int LINE_BYTES = $bits(cache_pkg::line_be_t);

	cache_pkg::way_entry_t entry_in;
	cache_pkg::line_t line_in;
	logic store_load;

	assign bus.hit = bus.entry.valid && (bus.entry.tag == bus.tag);

	assign store_load = bus.fill | bus.write_hit;

	always_comb
	begin
		entry_in.valid = 1'b1;
		entry_in.dirty = bus.write_hit; // a fill leaves the line clean
		entry_in.tag = bus.tag;
		if (bus.fill)
			line_in = bus.fill_line;
		else
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (bus.be_line[b])
					line_in[8*b +: 8] = bus.wdata_line[8*b +: 8];
				else
					line_in[8*b +: 8] = bus.line[8*b +: 8];
			end
		end
	end

	set_store #(
		.entry_t(cache_pkg::way_entry_t)
	) u_entry_store (
		.clk,
		.arst_n,
		.read(bus.lookup),
		.load(store_load),
		.index(bus.index),
		.data_in(entry_in),
		.data_out(bus.entry)
	);

	set_store #(
		.entry_t(cache_pkg::line_t)
	) u_line_store (
		.clk,
		.arst_n,
		.read(bus.lookup),
		.load(store_load),
		.index(bus.index),
		.data_in(line_in),
		.data_out(bus.line)
	);

endmodule

// File: design/set_store.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module set_store #(
	parameter type entry_t = logic
)
(
	input logic clk,
	input logic arst_n,
	input logic read,
	input logic load,
	input cache_pkg::index_t index,
	input entry_t data_in,
	output entry_t data_out
);

	localparam int NUM_SETS = 2**`CACHE_INDEX_W;

	entry_t mem [NUM_SETS];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_SETS; i++)
				mem[i] <= '0;
			data_out <= '0;
		end
		else
		begin
			if (load)
				mem[index] <= data_in;
			if (load)
				data_out <= data_in; // a write is visible on the output right away
			else if (read)
				data_out <= mem[index];
		end
	end

endmodule

// File: design/way_if.sv
`timescale 1ns/1ps

interface way_if;

	cache_pkg::index_t index;
	cache_pkg::tag_t tag;
	cache_pkg::line_t wdata_line; // processor word repeated over the line
	cache_pkg::line_be_t be_line;

	logic lookup;
	logic fill;
	logic write_hit;
	cache_pkg::line_t fill_line;

	logic hit;
	cache_pkg::way_entry_t entry;
	cache_pkg::line_t line;

	modport way (input index, tag, wdata_line, be_line, lookup, fill, write_hit, fill_line,
		output hit, entry, line);

	modport feed (output index, tag, wdata_line, be_line);

	// the selector also needs the index and lookup for its own LRU store
	modport drain (input index, lookup, hit, entry, line);

endinterface

// File: design/way_select.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module way_select (
	input logic clk,
	input logic arst_n,
	way_if.drain ways [`CACHE_WAYS],
	input logic update_lru,
	input logic evicting,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output cache_pkg::tag_t victim_tag,
	output cache_pkg::line_t line_out
);

	logic [`CACHE_WAYS-1:0] way_hit;
	cache_pkg::way_entry_t way_entry [`CACHE_WAYS];
	cache_pkg::line_t way_line [`CACHE_WAYS];
	logic lru_way;
	logic lru_next;

	for (genvar g = 0; g < `CACHE_WAYS; g++)
	begin : g_tap
		assign way_hit[g] = ways[g].hit;
		assign way_entry[g] = ways[g].entry;
		assign way_line[g] = ways[g].line;
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// after a hit the other way becomes the least recently used
	assign lru_next = ~hit_way;

	set_store #(
		.entry_t(logic)
	) u_lru_store (
		.clk,
		.arst_n,
		.read(ways[0].lookup),
		.load(update_lru),
		.index(ways[0].index),
		.data_in(lru_next),
		.data_out(lru_way)
	);

	always_comb
	begin
		// an empty way is used before anything is evicted
		if (!way_entry[0].valid)
			victim_way = 1'b0;
		else if (!way_entry[1].valid)
			victim_way = 1'b1;
		else
			victim_way = lru_way;
	end

	assign victim_dirty = way_entry[victim_way].valid && way_entry[victim_way].dirty;
	assign victim_tag = way_entry[victim_way].tag;

	assign line_out = evicting ? way_line[victim_way] : way_line[hit_way];

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f vlog.f -o cache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ] || grep -qF "** FAIL **" "$LOG"; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

// File: vlog.f
+incdir+design
design/cache_pkg.sv
design/way_if.sv
design/set_store.sv
design/bus_adapter.sv
design/cache_way.sv
design/way_select.sv
design/cache_ctrl.sv
design/cache_top.sv
bench/cache_properties.sv
bench/cache_tb.sv
